// File: hdl/cam_consts.svh
`ifndef CAM_CONSTS_SVH
`define CAM_CONSTS_SVH

// ------------------------------------------------------------
//  video sizes
// ------------------------------------------------------------

// one bayer sample from the sensor receiver
`define CAM_RAW_BITS        10

// column and row counters
`define CAM_COORD_BITS      12

// line buffer holds sample pairs, so max raw width is 2048
`define CAM_LINE_PAIRS      1024

// ------------------------------------------------------------
//  register map
// ------------------------------------------------------------

`define CAM_REG_CTRL        2'd0
`define CAM_REG_SIZE        2'd1
`define CAM_REG_STATUS      2'd2

`endif

// File: hdl/video_pkg.sv
`include "cam_consts.svh"

package video_pkg;

    // raw sample as delivered by the receiver
    typedef logic [`CAM_RAW_BITS-1:0] raw_sample_t;

    // binned output pixel
    typedef struct packed {
        logic   [7:0]   r;
        logic   [7:0]   g;
        logic   [7:0]   b;
    } rgb_pixel_t;

    // colour found at position (0,0) of every quad
    typedef enum logic [1:0] {
        BAYER_RGGB  = 2'd0,
        BAYER_GRBG  = 2'd1,
        BAYER_GBRG  = 2'd2,
        BAYER_BGGR  = 2'd3
    } bayer_phase_t;

endpackage

// File: hdl/regs_pkg.sv
package regs_pkg;

    typedef logic [1:0] reg_addr_t;

    // ctrl word, clear bit is a strobe and reads back as 0
    typedef struct packed {
        logic   [27:0]              zero;
        logic                       err_clear;
        video_pkg::bayer_phase_t    phase;
        logic                       enable;
    } ctrl_fields_t;

    typedef struct packed {
        logic   [15:0]  height;
        logic   [15:0]  width;
    } size_fields_t;

    typedef struct packed {
        logic   [14:0]  zero;
        logic           size_error;
        logic   [15:0]  frame_count;
    } status_fields_t;

    // one bus word, decoded by address
    typedef union packed {
        ctrl_fields_t   ctrl;
        size_fields_t   size;
        status_fields_t status;
    } reg_word_t;

endpackage

// File: hdl/cam_regs.sv
`timescale 1ns/1ns
`default_nettype none
`include "cam_consts.svh"

module cam_regs
        (
            input   logic                           aclk        ,
            input   logic                           reset       ,

            input   logic                           reg_req     ,
            input   logic                           reg_write   ,
            input   regs_pkg::reg_addr_t            reg_addr    ,
            input   regs_pkg::reg_word_t            reg_wdata   ,
            output  regs_pkg::reg_word_t            reg_rdata   ,
            output  logic                           reg_ack     ,

            output  logic                           enable      ,
            output  video_pkg::bayer_phase_t        phase       ,
            output  logic   [`CAM_COORD_BITS-1:0]   width       ,
            output  logic   [`CAM_COORD_BITS-1:0]   height      ,
            output  logic                           error_clear ,
            input   logic   [15:0]                  frame_count ,
            input   logic                           size_error
        );

    import video_pkg::*;

    logic   [15:0]  width_q;
    logic   [15:0]  height_q;
    logic           wr_en;

    // first edge of a request only
    assign wr_en  = reg_req && !reg_ack && reg_write;

    assign width  = width_q[`CAM_COORD_BITS-1:0];
    assign height = height_q[`CAM_COORD_BITS-1:0];

    // ------------------------------------------------------------
    //  handshake and write
    // ------------------------------------------------------------

    always_ff @(posedge aclk) begin
        if (reset) begin
            reg_ack     <= 1'b0;
            enable      <= 1'b0;
            phase       <= BAYER_RGGB;
            width_q     <= '0;
            height_q    <= '0;
            error_clear <= 1'b0;
        end
        else begin
            // ack follows req one cycle late, both edges
            reg_ack     <= reg_req;
            error_clear <= 1'b0;
            if (wr_en) begin
                case (reg_addr)
                    `CAM_REG_CTRL: begin
                        enable      <= reg_wdata.ctrl.enable;
                        phase       <= reg_wdata.ctrl.phase;
                        error_clear <= reg_wdata.ctrl.err_clear;
                    end
                    `CAM_REG_SIZE: begin
                        width_q     <= reg_wdata.size.width;
                        height_q    <= reg_wdata.size.height;
                    end
                    default: begin
                        // status is read only
                    end
                endcase
            end
        end
    end

    // ------------------------------------------------------------
    //  read back
    // ------------------------------------------------------------

    always_comb begin
        reg_rdata = '0;
        case (reg_addr)
            `CAM_REG_CTRL: begin
                reg_rdata.ctrl.enable = enable;
                reg_rdata.ctrl.phase  = phase;
            end
            `CAM_REG_SIZE: begin
                reg_rdata.size.width  = width_q;
                reg_rdata.size.height = height_q;
            end
            `CAM_REG_STATUS: begin
                reg_rdata.status.frame_count = frame_count;
                reg_rdata.status.size_error  = size_error;
            end
            default: begin
                reg_rdata = '0;
            end
        endcase
    end

endmodule

`default_nettype wire

// File: hdl/raw_framer.sv
`timescale 1ns/1ns
`default_nettype none
`include "cam_consts.svh"

module raw_framer
        (
            input   logic                           aclk            ,
            input   logic                           reset           ,
            input   logic                           enable          ,
            input   logic   [`CAM_COORD_BITS-1:0]   width           ,
            input   logic   [`CAM_COORD_BITS-1:0]   height          ,
            input   logic                           error_clear     ,

            input   logic                           in_valid        ,
            output  logic                           in_ready        ,
            input   video_pkg::raw_sample_t         in_data         ,
            input   logic                           in_user         ,
            input   logic                           in_last         ,

            output  logic                           pix_valid       ,
            input   logic                           pix_ready       ,
            output  video_pkg::raw_sample_t         pix_data        ,
            output  logic                           pix_col_odd     ,
            output  logic                           pix_row_odd     ,
            output  logic                           pix_frame_start ,
            output  logic                           pix_line_end    ,

            output  logic   [15:0]                  frame_count     ,
            output  logic                           size_error
        );

    logic   [`CAM_COORD_BITS-1:0]   col_q;
    logic   [`CAM_COORD_BITS-1:0]   row_q;
    logic                           started_q;
    logic   [`CAM_COORD_BITS-1:0]   col;
    logic   [`CAM_COORD_BITS-1:0]   row;
    logic   [`CAM_COORD_BITS-1:0]   last_col;
    logic   [`CAM_COORD_BITS-1:0]   last_row;
    logic                           accept;
    logic                           bad_end;
    logic                           bad_wrap;
    logic                           bad_frame;

    // frame start restarts position at zero
    assign col      = in_user ? '0 : col_q;
    assign row      = in_user ? '0 : row_q;
    assign last_col = width - 1'b1;
    assign last_row = height - 1'b1;

    // disabled: swallow everything
    assign in_ready = enable ? pix_ready : 1'b1;
    assign accept   = in_valid && in_ready;

    assign pix_valid       = in_valid && enable;
    assign pix_data        = in_data;
    assign pix_col_odd     = col[0];
    assign pix_row_odd     = row[0];
    assign pix_frame_start = in_user;
    assign pix_line_end    = in_last;

    // ------------------------------------------------------------
    //  size checks
    // ------------------------------------------------------------

    assign bad_end   = in_last && (col != last_col);
    assign bad_wrap  = !in_last && (col == last_col);
    assign bad_frame = in_user && started_q && (row_q != height);

    always_ff @(posedge aclk) begin
        if (reset) begin
            col_q       <= '0;
            row_q       <= '0;
            started_q   <= 1'b0;
            frame_count <= '0;
            size_error  <= 1'b0;
        end
        else begin
            if (accept) begin
                started_q <= started_q || in_user;
                if (in_last) begin
                    col_q <= '0;
                    row_q <= row + 1'b1;
                end
                else begin
                    col_q <= col + 1'b1;
                    row_q <= row;
                end
            end

            if (accept && enable && in_last && (row == last_row)) begin
                frame_count <= frame_count + 1'b1;
            end

            // sticky, a new error wins over clear
            if (accept && (bad_end || bad_wrap || bad_frame)) begin
                size_error <= 1'b1;
            end
            else if (error_clear) begin
                size_error <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

// File: hdl/bayer_binning.sv
`timescale 1ns/1ns
`default_nettype none
`include "cam_consts.svh"

module bayer_binning
        (
            input   logic                       aclk            ,
            input   logic                       reset           ,
            input   video_pkg::bayer_phase_t    phase           ,

            input   logic                       pix_valid       ,
            output  logic                       pix_ready       ,
            input   video_pkg::raw_sample_t     pix_data        ,
            input   logic                       pix_col_odd     ,
            input   logic                       pix_row_odd     ,
            input   logic                       pix_frame_start ,
            input   logic                       pix_line_end    ,

            output  logic                       out_valid       ,
            input   logic                       out_ready       ,
            output  video_pkg::rgb_pixel_t      out_data        ,
            output  logic                       out_user        ,
            output  logic                       out_last
        );

    import video_pkg::*;

    localparam int PAIR_BITS = $clog2(`CAM_LINE_PAIRS);

    logic   [2*`CAM_RAW_BITS-1:0]   line_mem [`CAM_LINE_PAIRS];
    logic   [2*`CAM_RAW_BITS-1:0]   line_rd;
    logic   [PAIR_BITS-1:0]         pair_q;
    raw_sample_t                    left_q;
    logic                           sof_q;
    logic                           accept;
    logic                           quad_done;
    raw_sample_t                    s00;
    raw_sample_t                    s01;
    raw_sample_t                    s10;
    raw_sample_t                    s11;
    logic   [`CAM_RAW_BITS:0]       g_sum;
    rgb_pixel_t                     quad_rgb;

    function automatic logic [7:0] top8(input raw_sample_t s);
        return s[`CAM_RAW_BITS-1 -: 8];
    endfunction

    // stall only when the output register is full and blocked
    assign pix_ready = !out_valid || out_ready;
    assign accept    = pix_valid && pix_ready;
    assign quad_done = accept && pix_row_odd && pix_col_odd;

    // ------------------------------------------------------------
    //  line buffer
    // ------------------------------------------------------------

    always_ff @(posedge aclk) begin
        if (accept && !pix_row_odd && pix_col_odd) begin
            line_mem[pair_q] <= {left_q, pix_data};
        end
        line_rd <= line_mem[pair_q];
        if (accept && !pix_col_odd) begin
            left_q <= pix_data;
        end
    end

    // quad as top pair from buffer, bottom pair from stream
    assign s00 = line_rd[2*`CAM_RAW_BITS-1:`CAM_RAW_BITS];
    assign s01 = line_rd[`CAM_RAW_BITS-1:0];
    assign s10 = left_q;
    assign s11 = pix_data;

    always_comb begin
        case (phase)
            BAYER_RGGB: begin
                quad_rgb.r = top8(s00);
                quad_rgb.b = top8(s11);
                g_sum      = s01 + s10;
            end
            BAYER_GRBG: begin
                quad_rgb.r = top8(s01);
                quad_rgb.b = top8(s10);
                g_sum      = s00 + s11;
            end
            BAYER_GBRG: begin
                quad_rgb.r = top8(s10);
                quad_rgb.b = top8(s01);
                g_sum      = s00 + s11;
            end
            default: begin
                quad_rgb.r = top8(s11);
                quad_rgb.b = top8(s00);
                g_sum      = s01 + s10;
            end
        endcase
        quad_rgb.g = 8'(g_sum >> 3);
    end

    // ------------------------------------------------------------
    //  control and output register
    // ------------------------------------------------------------

    always_ff @(posedge aclk) begin
        if (reset) begin
            pair_q    <= '0;
            sof_q     <= 1'b0;
            out_valid <= 1'b0;
        end
        else begin
            if (accept) begin
                if (pix_frame_start || pix_line_end) begin
                    pair_q <= '0;
                end
                else if (pix_col_odd) begin
                    pair_q <= pair_q + 1'b1;
                end
            end

            if (accept && pix_frame_start) begin
                sof_q <= 1'b1;
            end
            else if (quad_done) begin
                sof_q <= 1'b0;
            end

            if (quad_done) begin
                out_valid <= 1'b1;
            end
            else if (out_ready) begin
                out_valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge aclk) begin
        if (quad_done) begin
            out_data <= quad_rgb;
            out_user <= sof_q;
            out_last <= pix_line_end;
        end
    end

endmodule

`default_nettype wire

// File: hdl/cam_pipeline.sv
`timescale 1ns/1ns
`default_nettype none
`include "cam_consts.svh"

module cam_pipeline
        (
            input   logic                       aclk        ,
            input   logic                       reset       ,

            input   logic                       reg_req     ,
            input   logic                       reg_write   ,
            input   regs_pkg::reg_addr_t        reg_addr    ,
            input   regs_pkg::reg_word_t        reg_wdata   ,
            output  regs_pkg::reg_word_t        reg_rdata   ,
            output  logic                       reg_ack     ,

            input   logic                       in_valid    ,
            output  logic                       in_ready    ,
            input   video_pkg::raw_sample_t     in_data     ,
            input   logic                       in_user     ,
            input   logic                       in_last     ,

            output  logic                       out_valid   ,
            input   logic                       out_ready   ,
            output  video_pkg::rgb_pixel_t      out_data    ,
            output  logic                       out_user    ,
            output  logic                       out_last
        );

    import video_pkg::*;

    logic                           enable;
    bayer_phase_t                   phase;
    logic   [`CAM_COORD_BITS-1:0]   width;
    logic   [`CAM_COORD_BITS-1:0]   height;
    logic                           error_clear;
    logic   [15:0]                  frame_count;
    logic                           size_error;

    logic                           pix_valid;
    logic                           pix_ready;
    raw_sample_t                    pix_data;
    logic                           pix_col_odd;
    logic                           pix_row_odd;
    logic                           pix_frame_start;
    logic                           pix_line_end;

    // ------------------------------------------------------------
    //  registers
    // ------------------------------------------------------------

    cam_regs
        u_cam_regs
            (
                .aclk           (aclk           ),
                .reset          (reset          ),
                .reg_req        (reg_req        ),
                .reg_write      (reg_write      ),
                .reg_addr       (reg_addr       ),
                .reg_wdata      (reg_wdata      ),
                .reg_rdata      (reg_rdata      ),
                .reg_ack        (reg_ack        ),
                .enable         (enable         ),
                .phase          (phase          ),
                .width          (width          ),
                .height         (height         ),
                .error_clear    (error_clear    ),
                .frame_count    (frame_count    ),
                .size_error     (size_error     )
            );

    // ------------------------------------------------------------
    //  raw framing and binning
    // ------------------------------------------------------------

    raw_framer
        u_raw_framer
            (
                .aclk               (aclk           ),
                .reset              (reset          ),
                .enable             (enable         ),
                .width              (width          ),
                .height             (height         ),
                .error_clear        (error_clear    ),
                .in_valid           (in_valid       ),
                .in_ready           (in_ready       ),
                .in_data            (in_data        ),
                .in_user            (in_user        ),
                .in_last            (in_last        ),
                .pix_valid          (pix_valid      ),
                .pix_ready          (pix_ready      ),
                .pix_data           (pix_data       ),
                .pix_col_odd        (pix_col_odd    ),
                .pix_row_odd        (pix_row_odd    ),
                .pix_frame_start    (pix_frame_start),
                .pix_line_end       (pix_line_end   ),
                .frame_count        (frame_count    ),
                .size_error         (size_error     )
            );

    bayer_binning
        u_bayer_binning
            (
                .aclk               (aclk           ),
                .reset              (reset          ),
                .phase              (phase          ),
                .pix_valid          (pix_valid      ),
                .pix_ready          (pix_ready      ),
                .pix_data           (pix_data       ),
                .pix_col_odd        (pix_col_odd    ),
                .pix_row_odd        (pix_row_odd    ),
                .pix_frame_start    (pix_frame_start),
                .pix_line_end       (pix_line_end   ),
                .out_valid          (out_valid      ),
                .out_ready          (out_ready      ),
                .out_data           (out_data       ),
                .out_user           (out_user       ),
                .out_last           (out_last       )
            );

endmodule

`default_nettype wire

// File: verif/tb_cam_pipeline.sv
`timescale 1ns/1ns
`include "cam_consts.svh"

module tb_cam_pipeline;

    import video_pkg::*;
    import regs_pkg::*;

    localparam int FRAME_W        = 8;
    localparam int FRAME_H        = 8;
    localparam int TIMEOUT_CYCLES = 2000;
    localparam int IDLE_CYCLES    = 60;

    logic           aclk = 1'b0;
    logic           reset;
    logic           reg_req;
    logic           reg_write;
    reg_addr_t      reg_addr;
    reg_word_t      reg_wdata;
    reg_word_t      reg_rdata;
    logic           reg_ack;
    logic           in_valid;
    logic           in_ready;
    raw_sample_t    in_data;
    logic           in_user;
    logic           in_last;
    logic           out_valid;
    logic           out_ready;
    rgb_pixel_t     out_data;
    logic           out_user;
    logic           out_last;

    integer         seed = 14;
    int             frames_done = 0;
    raw_sample_t    frame_raw [FRAME_H][FRAME_W];
    rgb_pixel_t     exp_rgb [$];
    logic   [1:0]   exp_flags [$];

    cam_pipeline UUT (
        .aclk       (aclk       ),
        .reset      (reset      ),
        .reg_req    (reg_req    ),
        .reg_write  (reg_write  ),
        .reg_addr   (reg_addr   ),
        .reg_wdata  (reg_wdata  ),
        .reg_rdata  (reg_rdata  ),
        .reg_ack    (reg_ack    ),
        .in_valid   (in_valid   ),
        .in_ready   (in_ready   ),
        .in_data    (in_data    ),
        .in_user    (in_user    ),
        .in_last    (in_last    ),
        .out_valid  (out_valid  ),
        .out_ready  (out_ready  ),
        .out_data   (out_data   ),
        .out_user   (out_user   ),
        .out_last   (out_last   )
    );

    always #10 aclk = ~aclk;

    // ------------------------------------------------------------
    //  reference model and compare helpers
    // ------------------------------------------------------------

    // quad index: 0 top left, 1 top right, 2 bottom left, 3 bottom right
    function automatic rgb_pixel_t bin_pixel(input raw_sample_t s00, input raw_sample_t s01,
                                             input raw_sample_t s10, input raw_sample_t s11,
                                             input bayer_phase_t ph);
        raw_sample_t    quad [4];
        int             red_at;
        int             green_sum;
        rgb_pixel_t     px;
        quad[0] = s00;
        quad[1] = s01;
        quad[2] = s10;
        quad[3] = s11;
        case (ph)
            BAYER_RGGB: red_at = 0;
            BAYER_GRBG: red_at = 1;
            BAYER_GBRG: red_at = 2;
            default:    red_at = 3;
        endcase
        // blue sits diagonal to red, greens are the other two
        green_sum = quad[0] + quad[1] + quad[2] + quad[3] - quad[red_at] - quad[3 - red_at];
        px.r = quad[red_at][`CAM_RAW_BITS-1 -: 8];
        px.g = 8'(green_sum >> 3);
        px.b = quad[3 - red_at][`CAM_RAW_BITS-1 -: 8];
        return px;
    endfunction

    task automatic abort_run();
        $display("Testbench failed");
        $fatal(1);
    endtask

    task automatic check_rgb(input string name, input rgb_pixel_t got, input rgb_pixel_t exp);
        if (got !== exp) begin
            $display("FAIL %s got %h expected %h", name, got, exp);
            abort_run();
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("FAIL %s got %h expected %h", name, got, exp);
            abort_run();
        end
    endtask

    task automatic check_reg(input string name, input reg_word_t got, input reg_word_t exp);
        if (got !== exp) begin
            $display("FAIL %s got %h expected %h", name, got, exp);
            abort_run();
        end
    endtask

    // ------------------------------------------------------------
    //  register driver
    // ------------------------------------------------------------

    task automatic wait_reg_ack(input logic level, output reg_word_t data);
        int     cycles;
        bit     seen;
        seen = 1'b0;
        data = '0;
        for (cycles = 0; cycles < TIMEOUT_CYCLES && !seen; cycles++) begin
            @(posedge aclk);
            if (reg_ack === level) begin
                seen = 1'b1;
                data = reg_rdata;
            end
        end
        if (!seen) begin
            $display("timeout waiting for reg_ack to become %0d", level);
            abort_run();
        end
    endtask

    task automatic reg_access(input logic write, input reg_addr_t addr, input reg_word_t wdata,
                              output reg_word_t rdata);
        reg_word_t  dropped;
        @(negedge aclk);
        reg_req   = 1'b1;
        reg_write = write;
        reg_addr  = addr;
        reg_wdata = wdata;
        wait_reg_ack(1'b1, rdata);
        @(negedge aclk);
        reg_req   = 1'b0;
        reg_write = 1'b0;
        wait_reg_ack(1'b0, dropped);
    endtask

    task automatic write_ctrl(input logic en, input bayer_phase_t ph, input logic clr);
        reg_word_t  w;
        reg_word_t  rd;
        w = '0;
        w.ctrl.enable    = en;
        w.ctrl.phase     = ph;
        w.ctrl.err_clear = clr;
        reg_access(1'b1, `CAM_REG_CTRL, w, rd);
    endtask

    task automatic read_check(input string name, input reg_addr_t addr, input reg_word_t exp);
        reg_word_t  got;
        reg_access(1'b0, addr, '0, got);
        check_reg(name, got, exp);
    endtask

    task automatic status_check(input int count, input logic err);
        reg_word_t  exp;
        exp = '0;
        exp.status.frame_count = 16'(count);
        exp.status.size_error  = err;
        read_check("STATUS", `CAM_REG_STATUS, exp);
    endtask

    // ------------------------------------------------------------
    //  stream source and sink
    // ------------------------------------------------------------

    task automatic fill_frame();
        int     r;
        int     c;
        for (r = 0; r < FRAME_H; r++) begin
            for (c = 0; c < FRAME_W; c++) begin
                frame_raw[r][c] = `CAM_RAW_BITS'($random(seed));
            end
        end
    endtask

    // short_row must be odd so that the row above is complete
    task automatic queue_expected(input int short_row, input int short_len,
                                  input bayer_phase_t ph);
        int     r;
        int     k;
        int     len;
        logic   first;
        first = 1'b1;
        for (r = 1; r < FRAME_H; r += 2) begin
            len = (r == short_row) ? short_len : FRAME_W;
            for (k = 0; k < len / 2; k++) begin
                exp_rgb.push_back(bin_pixel(frame_raw[r-1][2*k], frame_raw[r-1][2*k+1],
                                            frame_raw[r][2*k], frame_raw[r][2*k+1], ph));
                exp_flags.push_back({first, (2*k+1 == len-1)});
                first = 1'b0;
            end
        end
    endtask

    task automatic send_sample(input raw_sample_t data, input logic user, input logic last);
        int     cycles;
        bit     taken;
        taken = 1'b0;
        @(negedge aclk);
        in_valid = 1'b1;
        in_data  = data;
        in_user  = user;
        in_last  = last;
        for (cycles = 0; cycles < TIMEOUT_CYCLES && !taken; cycles++) begin
            @(posedge aclk);
            taken = in_ready;
        end
        if (!taken) begin
            $display("timeout waiting for in_ready");
            abort_run();
        end
    endtask

    task automatic send_frame(input int short_row, input int short_len);
        int     r;
        int     c;
        int     len;
        for (r = 0; r < FRAME_H; r++) begin
            len = (r == short_row) ? short_len : FRAME_W;
            for (c = 0; c < len; c++) begin
                send_sample(frame_raw[r][c], (r == 0 && c == 0), (c == len - 1));
            end
        end
        @(negedge aclk);
        in_valid = 1'b0;
        in_user  = 1'b0;
        in_last  = 1'b0;
    endtask

    task automatic wait_drained();
        int     cycles;
        bit     empty;
        empty = 1'b0;
        for (cycles = 0; cycles < TIMEOUT_CYCLES && !empty; cycles++) begin
            @(negedge aclk);
            empty = (exp_rgb.size() == 0);
        end
        if (!empty) begin
            $display("timeout with %0d expected pixels never output", exp_rgb.size());
            abort_run();
        end
    endtask

    task automatic watch_idle();
        int     cycles;
        for (cycles = 0; cycles < IDLE_CYCLES; cycles++) begin
            @(negedge aclk);
            if (out_valid) begin
                $display("output pixel appeared while the pipeline was disabled");
                abort_run();
            end
        end
    endtask

    task automatic run_frame(input bayer_phase_t ph, input int short_row, input int short_len,
                             input logic err);
        write_ctrl(1'b1, ph, 1'b0);
        queue_expected(short_row, short_len, ph);
        send_frame(short_row, short_len);
        wait_drained();
        frames_done++;
        status_check(frames_done, err);
    endtask

    // random back-pressure
    always @(negedge aclk) begin
        out_ready = ($random(seed) & 3) != 0;
    end

    always @(posedge aclk) begin : compare_output
        rgb_pixel_t     exp_px;
        logic   [1:0]   exp_fl;
        if (!reset && out_valid && out_ready) begin
            if (exp_rgb.size() == 0) begin
                $display("output pixel arrived when none was expected");
                abort_run();
            end
            else begin
                exp_px = exp_rgb.pop_front();
                exp_fl = exp_flags.pop_front();
                check_rgb("out_data", out_data, exp_px);
                check_flag("out_user", out_user, exp_fl[1]);
                check_flag("out_last", out_last, exp_fl[0]);
            end
        end
    end

    // ------------------------------------------------------------
    //  test sequence
    // ------------------------------------------------------------

    initial begin
        reg_word_t  w;
        reg_word_t  rd;
        reset     = 1'b1;
        reg_req   = 1'b0;
        reg_write = 1'b0;
        reg_addr  = '0;
        reg_wdata = '0;
        in_valid  = 1'b0;
        in_data   = '0;
        in_user   = 1'b0;
        in_last   = 1'b0;
        out_ready = 1'b0;
        repeat (2) @(posedge aclk);
        @(negedge aclk);
        reset = 1'b0;
        @(posedge aclk);
        fill_frame();

        // register read back
        w = '0;
        w.size.width  = 16'(FRAME_W);
        w.size.height = 16'(FRAME_H);
        reg_access(1'b1, `CAM_REG_SIZE, w, rd);
        read_check("SIZE", `CAM_REG_SIZE, w);
        write_ctrl(1'b1, BAYER_GBRG, 1'b1);
        w = '0;
        w.ctrl.enable = 1'b1;
        w.ctrl.phase  = BAYER_GBRG;
        read_check("CTRL", `CAM_REG_CTRL, w);
        status_check(0, 1'b0);
        w = '1;
        reg_access(1'b1, `CAM_REG_STATUS, w, rd);
        status_check(0, 1'b0);

        // same frame data in all four phases
        run_frame(BAYER_RGGB, -1, 0, 1'b0);
        run_frame(BAYER_GRBG, -1, 0, 1'b0);
        run_frame(BAYER_GBRG, -1, 0, 1'b0);
        run_frame(BAYER_BGGR, -1, 0, 1'b0);

        // line 3 ends two samples early
        run_frame(BAYER_BGGR, 3, FRAME_W - 2, 1'b1);
        write_ctrl(1'b1, BAYER_BGGR, 1'b1);
        status_check(frames_done, 1'b0);

        // disabled, frame is swallowed
        write_ctrl(1'b0, BAYER_RGGB, 1'b0);
        send_frame(-1, 0);
        watch_idle();
        status_check(frames_done, 1'b0);

        $display("Testbench passed");
        $finish;
    end

endmodule

// File: verilog.f
+incdir+hdl
hdl/video_pkg.sv
hdl/regs_pkg.sv
hdl/cam_regs.sv
hdl/raw_framer.sv
hdl/bayer_binning.sv
hdl/cam_pipeline.sv
verif/tb_cam_pipeline.sv
